//--- include/x86_decode_config.svh
`ifndef X86_DECODE_CONFIG_SVH
`define X86_DECODE_CONFIG_SVH

// fetch window and prefix search depth, in bytes
`define X86_WINDOW_BYTES 16
`define X86_SCAN_BYTES 8

// attribute table: {map, opcode} address
`define X86_ATTR_AW 10
`define X86_ATTR_W 3

`endif

//--- verification/x86_decode_tb.sv
`timescale 1ns/1ps
`include "x86_decode_config.svh"

module x86_decode_tb
  import x86_insn_pkg::*;
();

  logic                                  clk;
  logic                                  rst;
  logic                                  insn_req;
  logic                                  load_req;
  logic [`X86_WINDOW_BYTES*8-1:0]        window_data;
  logic [`X86_ATTR_AW-1:0]               load_addr;
  logic [`X86_ATTR_W-1:0]                load_attr;
  logic                                  insn_ack;
  logic                                  load_ack;
  logic [3:0]                            insn_len;
  opcode_map_e                           insn_map;
  logic [7:0]                            insn_opcode;
  logic                                  insn_opsize;
  logic                                  insn_rex_present;
  logic [2:0]                            insn_prefix_count;
  logic                                  insn_fault;

  logic [31:0]                           lfsr;
  logic [`X86_ATTR_W-1:0]                ref_attr [1 << `X86_ATTR_AW];
  logic [`X86_ATTR_AW-1:0]               pool [16];
  logic [`X86_WINDOW_BYTES*8-1:0]        next_window;
  logic [3:0]                            exp_len;
  logic [1:0]                            exp_map;
  logic [7:0]                            exp_opcode;
  logic                                  exp_opsize;
  logic                                  exp_rex;
  logic [2:0]                            exp_pcount;
  logic                                  exp_fault;

  localparam logic [7:0] legacy_pfx [11] = '{8'h66, 8'h67, 8'hf2, 8'hf3, 8'hf0,
                                              8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65};

  x86_decode_top dut_i (.*);

  always #2 clk = ~clk;

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    $display("Result: FAILED");
    $fatal(1, "decode output check failed");
  endtask

  task automatic timed_out(input string what);
    $display("Timeout: %s", what);
    $display("Result: FAILED");
    $fatal(1, "handshake stalled");
  endtask

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic is_prefix(input logic [7:0] b);
    logic hit;
    hit = (b[7:4] == 4'h4); // rex
    foreach (legacy_pfx[i])
      if (legacy_pfx[i] == b)
        hit = 1'b1;
    return hit;
  endfunction

  function automatic logic [7:0] pick_prefix();
    int r;
    r = int'(rand_bits(5)) % 27;
    return (r < 11) ? legacy_pfx[r] : 8'h40 + 8'(r - 11);
  endfunction

  function automatic logic [3:0] expected_len(input int npfx, input int esc,
      input logic [2:0] attr, input logic [7:0] modrm, input logic [7:0] sib, input logic osz);
    int  n;
    logic sib_on;
    n = npfx + esc + 1;
    sib_on = attr[modrm_bit] && modrm[2:0] == 3'b100 && modrm[7:6] != 2'b11;
    if (attr[modrm_bit]) begin
      n = n + 1 + int'(sib_on);
      if (modrm[7:6] == 2'b01)
        n = n + 1;
      else if (modrm[7:6] == 2'b10 || (modrm[7:6] == 2'b00 &&
               (modrm[2:0] == 3'b101 || (sib_on && sib[2:0] == 3'b101))))
        n = n + 4;
    end
    if (attr[imm_bit])
      n = n + (!attr[immsz_bit] ? 1 : (osz ? 2 : 4));
    return (n > 15) ? 4'd15 : 4'(n);
  endfunction

  task automatic build_insn(input int npfx, input logic [9:0] addr, input logic [7:0] modrm,
                            input logic [7:0] sib, input logic force66);
    logic [7:0] win [16];
    logic [7:0] b;
    int         k;
    int         esc;
    exp_opsize = 1'b0;
    exp_rex = 1'b0;
    for (k = 0; k < npfx; k++) begin
      b = (force66 && k == 0) ? 8'h66 : pick_prefix();
      win[k] = b;
      if (b == 8'h66)
        exp_opsize = 1'b1;
      exp_rex = (b[7:4] == 4'h4); // only the last one counts
    end
    esc = (addr[9:8] == 2'd0) ? 0 : ((addr[9:8] == 2'd1) ? 1 : 2);
    if (esc != 0)
      win[k] = 8'h0f;
    if (esc == 2)
      win[k + 1] = (opcode_map_e'(addr[9:8]) == map_0f38) ? 8'h38 : 8'h3a;
    k = k + esc;
    win[k] = addr[7:0];
    win[k + 1] = modrm;
    win[k + 2] = sib;
    for (int i = k + 3; i < 16; i++)
      win[i] = 8'(rand_bits(8));
    for (int i = 0; i < 16; i++)
      next_window[8*i +: 8] = win[i];
    exp_map = addr[9:8];
    exp_opcode = addr[7:0];
    exp_pcount = 3'(npfx);
    exp_fault = 1'b0;
    exp_len = expected_len(npfx, esc, ref_attr[addr], modrm, sib, exp_opsize);
  endtask

  task automatic build_fault();
    for (int i = 0; i < 16; i++)
      next_window[8*i +: 8] = (i < 8) ? pick_prefix() : 8'(rand_bits(8));
    exp_fault = 1'b1;
    exp_len = 4'd0;
  endtask

  task automatic run_decode();
    int cnt;
    @(negedge clk);
    window_data = next_window;
    insn_req = 1'b1;
    cnt = 0;
    while (!insn_ack) begin
      @(negedge clk);
      cnt++;
      if (cnt > 100)
        timed_out("insn_ack never rose");
    end
    insn_req = 1'b0;
    cnt = 0;
    while (insn_ack) begin
      @(negedge clk);
      cnt++;
      if (cnt > 100)
        timed_out("insn_ack stuck high after insn_req fell");
    end
  endtask

  task automatic load_entry(input logic [9:0] addr, input logic [2:0] attr);
    int cnt;
    ref_attr[addr] = attr;
    @(negedge clk);
    load_addr = addr;
    load_attr = attr;
    load_req = 1'b1;
    cnt = 0;
    while (!load_ack) begin
      @(negedge clk);
      cnt++;
      if (cnt > 100)
        timed_out("load_ack never rose");
    end
    load_req = 1'b0;
    cnt = 0;
    while (load_ack) begin
      @(negedge clk);
      cnt++;
      if (cnt > 100)
        timed_out("load_ack stuck high after load_req fell");
    end
  endtask

  // buffered loads reach the table before the next decode
  task automatic wait_drained();
    int cnt;
    cnt = 0;
    while (dut_i.loader_i.count != 2'd0) begin
      @(negedge clk);
      cnt++;
      if (cnt > 200)
        timed_out("load buffer never drained into the table");
    end
  endtask

  a_len: assert property (@(posedge clk) disable iff (rst) $rose(insn_ack) |-> insn_len == exp_len)
    else mismatch("insn_len", 32'($sampled(insn_len)), 32'($sampled(exp_len)));
  a_fault: assert property (@(posedge clk) disable iff (rst)
    $rose(insn_ack) |-> insn_fault == exp_fault)
    else mismatch("insn_fault", 32'($sampled(insn_fault)), 32'($sampled(exp_fault)));
  a_map: assert property (@(posedge clk) disable iff (rst)
    $rose(insn_ack) && !exp_fault |-> insn_map == exp_map)
    else mismatch("insn_map", 32'($sampled(insn_map)), 32'($sampled(exp_map)));
  a_opcode: assert property (@(posedge clk) disable iff (rst)
    $rose(insn_ack) && !exp_fault |-> insn_opcode == exp_opcode)
    else mismatch("insn_opcode", 32'($sampled(insn_opcode)), 32'($sampled(exp_opcode)));
  a_opsize: assert property (@(posedge clk) disable iff (rst)
    $rose(insn_ack) && !exp_fault |-> insn_opsize == exp_opsize)
    else mismatch("insn_opsize", 32'($sampled(insn_opsize)), 32'($sampled(exp_opsize)));
  a_rex: assert property (@(posedge clk) disable iff (rst)
    $rose(insn_ack) && !exp_fault |-> insn_rex_present == exp_rex)
    else mismatch("insn_rex_present", 32'($sampled(insn_rex_present)), 32'($sampled(exp_rex)));
  a_pcount: assert property (@(posedge clk) disable iff (rst)
    $rose(insn_ack) && !exp_fault |-> insn_prefix_count == exp_pcount)
    else mismatch("insn_prefix_count", 32'($sampled(insn_prefix_count)),
                  32'($sampled(exp_pcount)));

  initial begin
    logic [7:0] op;
    logic [9:0] a1;
    logic [9:0] a2;
    int         idx;
    clk = 1'b0;
    rst = 1'b1;
    insn_req = 1'b0;
    load_req = 1'b0;
    window_data = '0;
    load_addr = '0;
    load_attr = '0;
    lfsr = 32'he3196406;
    foreach (ref_attr[i])
      ref_attr[i] = '0; // table clears on reset
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // pool entry p lives in map p % 4
    for (int p = 0; p < 16; p++) begin
      op = 8'(rand_bits(8));
      while ((p % 4 == 0 && (is_prefix(op) || op == 8'h0f)) ||
             (p % 4 == 1 && (op == 8'h38 || op == 8'h3a)))
        op = 8'(rand_bits(8));
      pool[p] = {2'(p % 4), op};
      load_entry(pool[p], 3'(rand_bits(3)));
    end
    load_entry({2'd0, 8'h8b}, 3'b001); // modrm only
    load_entry({2'd0, 8'h05}, 3'b110); // imm32, no modrm
    wait_drained();

    for (int m = 0; m < 4; m++) begin
      build_insn(0, pool[m], 8'(rand_bits(8)), 8'(rand_bits(8)), 1'b0);
      run_decode();
    end

    for (int n = 0; n < 40; n++) begin
      idx = int'(rand_bits(4));
      build_insn(int'(rand_bits(3)), pool[idx], 8'(rand_bits(8)), 8'(rand_bits(8)), 1'b0);
      run_decode();
    end
    build_insn(1 + int'(rand_bits(2)), {2'd0, 8'h05}, 8'(rand_bits(8)), 8'(rand_bits(8)), 1'b1);
    run_decode();

    for (int m = 0; m < 4; m++)
      for (int r = 0; r < 8; r++)
        for (int s = 0; s < 2; s++) begin
          build_insn(int'(rand_bits(2)), {2'd0, 8'h8b}, {2'(m), 3'(rand_bits(3)), 3'(r)},
                     {5'(rand_bits(5)), (s == 1) ? 3'b101 : 3'(rand_bits(3))}, 1'b0);
          run_decode();
        end

    repeat (4) begin
      build_fault();
      run_decode();
    end

    // loads racing a decode never touch the entry it reads
    repeat (6) begin
      idx = int'(rand_bits(4));
      build_insn(int'(rand_bits(3)), pool[idx], 8'(rand_bits(8)), 8'(rand_bits(8)), 1'b0);
      a1 = {2'd1, 8'(rand_bits(8))};
      while (a1 == pool[idx] || a1[7:0] == 8'h38 || a1[7:0] == 8'h3a)
        a1 = {2'd1, 8'(rand_bits(8))};
      a2 = 10'(rand_bits(10));
      while (a2 == pool[idx])
        a2 = 10'(rand_bits(10));
      fork
        run_decode();
        begin
          load_entry(a1, 3'(rand_bits(3)));
          load_entry(a2, 3'(rand_bits(3)));
        end
      join
      wait_drained();
      build_insn(0, a1, 8'(rand_bits(8)), 8'(rand_bits(8)), 1'b0);
      run_decode(); // map 0f read of the fresh entry
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog/attr_arbiter.sv
`timescale 1ns/1ps
`include "x86_decode_config.svh"

module attr_arbiter
  import x86_ctl_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ld_req,
  input  logic [`X86_ATTR_AW-1:0]  ld_addr,
  input  logic [`X86_ATTR_W-1:0]   ld_wdata,
  input  logic                     calc_req,
  input  logic [`X86_ATTR_AW-1:0]  calc_addr,
  input  logic [`X86_ATTR_W-1:0]   tbl_rdata,
  output logic                     ld_ack,
  output logic                     calc_ack,
  output logic [`X86_ATTR_W-1:0]   calc_rdata,
  output logic [`X86_ATTR_AW-1:0]  tbl_addr,
  output logic                     tbl_we,
  output logic [`X86_ATTR_W-1:0]   tbl_wdata
);

  arb_state_e state;
  requester_e owner;
  logic       owner_req;

  assign owner = (state == arb_grant_calc) ? req_calc : req_loader;
  assign owner_req = (owner == req_calc) ? calc_req : ld_req;

  assign tbl_addr = (owner == req_calc) ? calc_addr : ld_addr;
  assign tbl_wdata = ld_wdata;
  assign tbl_we = (state == arb_grant_load) && !ld_ack; // first grant cycle only
  assign calc_rdata = tbl_rdata; // held, address stays on calc until release

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= arb_idle;
      ld_ack <= 1'b0;
      calc_ack <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (ld_req)
            state <= arb_grant_load; // table updates first
          else if (calc_req)
            state <= arb_grant_calc;
        end
        arb_grant_load, arb_grant_calc: begin
          if (!ld_ack && !calc_ack) begin
            ld_ack <= (owner == req_loader);
            calc_ack <= (owner == req_calc);
          end else if (!owner_req) begin
            ld_ack <= 1'b0;
            calc_ack <= 1'b0;
            state <= arb_release;
          end
        end
        arb_release: state <= arb_idle;
        default: state <= arb_idle;
      endcase
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (rst)
    !(ld_ack && calc_ack));
  a_ld_ack_req: assert property (@(posedge clk) disable iff (rst)
    ld_ack |-> $past(ld_req));
  a_calc_ack_req: assert property (@(posedge clk) disable iff (rst)
    calc_ack |-> $past(calc_req));
  a_we_loader: assert property (@(posedge clk) disable iff (rst)
    tbl_we |-> owner == req_loader && ld_req);

endmodule

//--- verilog/attr_loader.sv
`timescale 1ns/1ps
`include "x86_decode_config.svh"

module attr_loader
  import x86_ctl_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     load_req,
  input  logic [`X86_ATTR_AW-1:0]  load_addr,
  input  logic [`X86_ATTR_W-1:0]   load_attr,
  input  logic                     ld_ack,
  output logic                     load_ack,
  output logic                     ld_req,
  output logic [`X86_ATTR_AW-1:0]  ld_addr,
  output logic [`X86_ATTR_W-1:0]   ld_wdata
);

  logic [`X86_ATTR_AW-1:0] fifo_addr [2];
  logic [`X86_ATTR_W-1:0]  fifo_attr [2];
  logic                    wr_ptr;
  logic                    rd_ptr;
  logic [1:0]              count;
  hs_state_e               in_st;
  hs_state_e               out_st;
  logic                    push;
  logic                    pop;

  assign push = (in_st == hs_idle) && load_req && count != 2'd2;
  assign pop = (out_st == hs_wait_ack) && ld_ack;
  assign ld_addr = fifo_addr[rd_ptr];
  assign ld_wdata = fifo_attr[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_addr[wr_ptr] <= load_addr;
      fifo_attr[wr_ptr] <= load_attr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count <= 2'd0;
      in_st <= hs_idle;
      out_st <= hs_idle;
      load_ack <= 1'b0;
      ld_req <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= !wr_ptr;
      if (pop)
        rd_ptr <= !rd_ptr;
      count <= count + 2'(push) - 2'(pop);

      // writer side
      case (in_st)
        hs_idle: if (push) in_st <= hs_wait_ack;
        hs_wait_ack: begin
          load_ack <= 1'b1;
          in_st <= hs_wait_drop;
        end
        hs_wait_drop: begin
          if (!load_req) begin
            load_ack <= 1'b0;
            in_st <= hs_idle;
          end
        end
        default: in_st <= hs_idle;
      endcase

      // table side, head entry until acked
      case (out_st)
        hs_idle: begin
          if (count != 2'd0) begin
            ld_req <= 1'b1;
            out_st <= hs_wait_ack;
          end
        end
        hs_wait_ack: begin
          if (ld_ack) begin
            ld_req <= 1'b0;
            out_st <= hs_wait_drop;
          end
        end
        hs_wait_drop: if (!ld_ack) out_st <= hs_idle;
        default: out_st <= hs_idle;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    count != 2'd3);

endmodule

//--- verilog/attr_table.sv
`timescale 1ns/1ps
`include "x86_decode_config.svh"

module attr_table (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`X86_ATTR_AW-1:0]  addr,
  input  logic                     we,
  input  logic [`X86_ATTR_W-1:0]   wdata,
  output logic [`X86_ATTR_W-1:0]   rdata
);

  logic [`X86_ATTR_W-1:0] mem [1 << `X86_ATTR_AW];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < (1 << `X86_ATTR_AW); i++)
        mem[i] <= '0;
      rdata <= '0;
    end else begin
      if (we)
        mem[addr] <= wdata;
      rdata <= mem[addr]; // old data on write
    end
  end

endmodule

//--- verilog/insn_length_calc.sv
`timescale 1ns/1ps
`include "x86_decode_config.svh"

module insn_length_calc
  import x86_insn_pkg::*, x86_ctl_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     insn_req,
  input  logic [2:0]               opcode_pos,
  input  logic [7:0]               opcode_byte,
  input  logic [1:0]               escape_len,
  input  opcode_map_e              op_map,
  input  logic [7:0]               modrm_byte,
  input  logic [7:0]               sib_byte,
  input  logic                     opsize,
  input  logic                     rex_present,
  input  logic [2:0]               prefix_count,
  input  logic                     no_opcode,
  input  logic                     calc_ack,
  input  logic [`X86_ATTR_W-1:0]   calc_rdata,
  output logic                     scan_start,
  output logic                     calc_req,
  output logic [`X86_ATTR_AW-1:0]  calc_addr,
  output logic                     insn_ack,
  output logic [3:0]               insn_len,
  output opcode_map_e              insn_map,
  output logic [7:0]               insn_opcode,
  output logic                     insn_opsize,
  output logic                     insn_rex_present,
  output logic [2:0]               insn_prefix_count,
  output logic                     insn_fault
);

  hs_state_e   st;
  logic        scan_pending;
  modrm_mode_e mode;
  logic [2:0]  rm;
  logic        has_modrm;
  logic        has_sib;
  logic [2:0]  disp_len;
  logic [2:0]  imm_len;
  logic [4:0]  len_sum;
  logic [3:0]  len_sat;

  assign scan_start = (st == hs_idle) && insn_req;
  assign calc_addr = {op_map, opcode_byte};

  assign mode = modrm_mode_e'(modrm_byte[7:6]);
  assign rm = modrm_byte[2:0];
  assign has_modrm = calc_rdata[modrm_bit];
  assign has_sib = has_modrm && rm == 3'b100 && mode != mod_reg;

  always_comb begin
    disp_len = 3'd0;
    imm_len = 3'd0;
    if (has_modrm) begin
      case (mode)
        mod_disp8: disp_len = 3'd1;
        mod_disp32: disp_len = 3'd4;
        mod_indirect: begin
          if (rm == 3'b101 || (has_sib && sib_byte[2:0] == 3'b101))
            disp_len = 3'd4; // rip-relative or no base
        end
        default: disp_len = 3'd0;
      endcase
    end
    if (calc_rdata[imm_bit]) begin
      if (imm_size_e'(calc_rdata[immsz_bit]) == imm_8)
        imm_len = 3'd1;
      else
        imm_len = opsize ? 3'd2 : 3'd4;
    end
  end

  assign len_sum = 5'(opcode_pos) + 5'(escape_len) + 5'd1 + 5'(has_modrm) + 5'(has_sib)
                 + 5'(disp_len) + 5'(imm_len);
  assign len_sat = (len_sum > 5'd15) ? 4'd15 : len_sum[3:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      st <= hs_idle;
      scan_pending <= 1'b0;
      calc_req <= 1'b0;
      insn_ack <= 1'b0;
    end else begin
      case (st)
        hs_idle: begin
          if (insn_req) begin
            st <= hs_wait_ack;
            scan_pending <= 1'b1;
          end
        end
        hs_wait_ack: begin
          if (scan_pending) begin
            scan_pending <= 1'b0;
            if (no_opcode) begin
              insn_ack <= 1'b1; // fault, skip the table
              st <= hs_wait_drop;
            end else begin
              calc_req <= 1'b1;
            end
          end else if (calc_req && calc_ack) begin
            calc_req <= 1'b0;
            insn_ack <= 1'b1;
            st <= hs_wait_drop;
          end
        end
        hs_wait_drop: begin
          if (!insn_req) begin
            insn_ack <= 1'b0;
            st <= hs_idle;
          end
        end
        default: st <= hs_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (st == hs_wait_ack && scan_pending) begin
      insn_map <= op_map;
      insn_opcode <= opcode_byte;
      insn_opsize <= opsize;
      insn_rex_present <= rex_present;
      insn_prefix_count <= prefix_count;
      insn_fault <= no_opcode;
      insn_len <= 4'd0;
    end
    if (calc_req && calc_ack)
      insn_len <= len_sat;
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(insn_ack) |-> $past(insn_req));

endmodule

//--- verilog/prefix_scan.sv
`timescale 1ns/1ps
`include "x86_decode_config.svh"

module prefix_scan
  import x86_insn_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic [`X86_WINDOW_BYTES*8-1:0]  window_data,
  output logic [2:0]                      opcode_pos,
  output logic [7:0]                      opcode_byte,
  output logic [1:0]                      escape_len,
  output opcode_map_e                     op_map,
  output logic [7:0]                      modrm_byte,
  output logic [7:0]                      sib_byte,
  output logic                            opsize,
  output logic                            rex_present,
  output logic [2:0]                      prefix_count,
  output logic                            no_opcode
);

  prefix_kind_e kind [`X86_SCAN_BYTES];
  logic         found;
  logic [2:0]   pos;
  logic         opsize_c;
  logic         rex_c;
  logic [1:0]   esc_c;
  opcode_map_e  map_c;
  int           op_idx;

  function automatic prefix_kind_e classify(input logic [7:0] b);
    case (b)
      8'h66: classify = pfx_opsize;
      8'h67: classify = pfx_addrsize;
      8'hf2, 8'hf3: classify = pfx_rep;
      8'hf0: classify = pfx_lock;
      8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65: classify = pfx_segment;
      default: classify = (b[7:4] == 4'h4) ? pfx_rex : pfx_none;
    endcase
  endfunction

  // first non-prefix byte is the opcode (or its escape)
  always_comb begin
    found = 1'b0;
    pos = 3'(`X86_SCAN_BYTES - 1);
    opsize_c = 1'b0;
    for (int i = 0; i < `X86_SCAN_BYTES; i++) begin
      kind[i] = classify(window_data[8*i +: 8]);
      if (!found && kind[i] == pfx_none) begin
        found = 1'b1;
        pos = i[2:0];
      end
      if (!found && kind[i] == pfx_opsize)
        opsize_c = 1'b1;
    end
  end

  // rex only takes effect right in front of the opcode
  assign rex_c = found && pos != 3'd0 && kind[pos - 3'd1] == pfx_rex;

  always_comb begin
    esc_c = 2'd0;
    map_c = map_legacy;
    if (window_data[8*pos +: 8] == 8'h0f) begin
      case (window_data[8*(pos+1) +: 8])
        8'h38: begin
          esc_c = 2'd2;
          map_c = map_0f38;
        end
        8'h3a: begin
          esc_c = 2'd2;
          map_c = map_0f3a;
        end
        default: begin
          esc_c = 2'd1;
          map_c = map_0f;
        end
      endcase
    end
    op_idx = int'(pos) + int'(esc_c);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      no_opcode <= 1'b0;
      opsize <= 1'b0;
      rex_present <= 1'b0;
      prefix_count <= 3'd0;
    end else if (start) begin
      no_opcode <= !found;
      opsize <= opsize_c;
      rex_present <= rex_c;
      prefix_count <= pos; // ignored rex still counts
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      opcode_pos <= pos;
      escape_len <= esc_c;
      op_map <= map_c;
      opcode_byte <= window_data[8*op_idx +: 8];
      modrm_byte <= window_data[8*(op_idx+1) +: 8];
      sib_byte <= window_data[8*(op_idx+2) +: 8];
    end
  end

  // result is read by the length calculator for a few cycles after each start
  a_start_spacing: assert property (@(posedge clk) disable iff (rst)
    start |=> !start [*2]);

endmodule

//--- verilog/x86_ctl_pkg.sv
package x86_ctl_pkg;

  typedef enum logic [1:0] {
    hs_idle,
    hs_wait_ack,
    hs_wait_drop
  } hs_state_e;

  typedef enum logic [1:0] {
    arb_idle,
    arb_grant_load,
    arb_grant_calc,
    arb_release
  } arb_state_e;

  typedef enum logic {
    req_loader = 1'b0,
    req_calc   = 1'b1
  } requester_e;

endpackage

//--- verilog/x86_decode_top.sv
`timescale 1ns/1ps
`include "x86_decode_config.svh"

module x86_decode_top
  import x86_insn_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic [`X86_WINDOW_BYTES*8-1:0]  window_data,
  input  logic                            insn_req,
  input  logic                            load_req,
  input  logic [`X86_ATTR_AW-1:0]         load_addr,
  input  logic [`X86_ATTR_W-1:0]          load_attr,
  output logic                            insn_ack,
  output logic                            load_ack,
  output logic [3:0]                      insn_len,
  output opcode_map_e                     insn_map,
  output logic [7:0]                      insn_opcode,
  output logic                            insn_opsize,
  output logic                            insn_rex_present,
  output logic [2:0]                      insn_prefix_count,
  output logic                            insn_fault
);

  logic                    scan_start;
  logic [2:0]              opcode_pos;
  logic [7:0]              opcode_byte;
  logic [1:0]              escape_len;
  opcode_map_e             op_map;
  logic [7:0]              modrm_byte;
  logic [7:0]              sib_byte;
  logic                    opsize;
  logic                    rex_present;
  logic [2:0]              prefix_count;
  logic                    no_opcode;
  logic                    ld_req;
  logic                    ld_ack;
  logic [`X86_ATTR_AW-1:0] ld_addr;
  logic [`X86_ATTR_W-1:0]  ld_wdata;
  logic                    calc_req;
  logic                    calc_ack;
  logic [`X86_ATTR_AW-1:0] calc_addr;
  logic [`X86_ATTR_W-1:0]  calc_rdata;
  logic [`X86_ATTR_AW-1:0] tbl_addr;
  logic                    tbl_we;
  logic [`X86_ATTR_W-1:0]  tbl_wdata;
  logic [`X86_ATTR_W-1:0]  tbl_rdata;

  prefix_scan scan_i (
    .clk, .rst,
    .start(scan_start),
    .window_data,
    .opcode_pos, .opcode_byte, .escape_len, .op_map,
    .modrm_byte, .sib_byte, .opsize, .rex_present,
    .prefix_count, .no_opcode
  );

  insn_length_calc calc_i (
    .clk, .rst, .insn_req,
    .opcode_pos, .opcode_byte, .escape_len, .op_map,
    .modrm_byte, .sib_byte, .opsize, .rex_present,
    .prefix_count, .no_opcode,
    .calc_ack, .calc_rdata, .scan_start, .calc_req, .calc_addr,
    .insn_ack, .insn_len, .insn_map, .insn_opcode, .insn_opsize,
    .insn_rex_present, .insn_prefix_count, .insn_fault
  );

  attr_loader loader_i (
    .clk, .rst, .load_req, .load_addr, .load_attr, .ld_ack,
    .load_ack, .ld_req, .ld_addr, .ld_wdata
  );

  attr_arbiter arb_i (
    .clk, .rst,
    .ld_req, .ld_addr, .ld_wdata,
    .calc_req, .calc_addr, .tbl_rdata,
    .ld_ack, .calc_ack, .calc_rdata,
    .tbl_addr, .tbl_we, .tbl_wdata
  );

  attr_table table_i (
    .clk, .rst,
    .addr(tbl_addr),
    .we(tbl_we),
    .wdata(tbl_wdata),
    .rdata(tbl_rdata)
  );

endmodule

//--- verilog/x86_insn_pkg.sv
package x86_insn_pkg;

  typedef enum logic [1:0] {
    map_legacy = 2'd0,
    map_0f     = 2'd1,
    map_0f38   = 2'd2,
    map_0f3a   = 2'd3
  } opcode_map_e;

  typedef enum logic {
    imm_8  = 1'b0,
    imm_32 = 1'b1
  } imm_size_e;

  // bit positions inside one table entry
  localparam int modrm_bit = 0;
  localparam int imm_bit   = 1;
  localparam int immsz_bit = 2;

  typedef enum logic [2:0] {
    pfx_none,
    pfx_opsize,   // 66
    pfx_addrsize, // 67
    pfx_rep,      // f2/f3
    pfx_lock,     // f0
    pfx_segment,
    pfx_rex       // 40-4f
  } prefix_kind_e;

  typedef enum logic [1:0] {
    mod_indirect = 2'b00,
    mod_disp8    = 2'b01,
    mod_disp32   = 2'b10,
    mod_reg      = 2'b11
  } modrm_mode_e;

endpackage

//--- x86_decode_top.f
+incdir+include
verilog/x86_insn_pkg.sv
verilog/x86_ctl_pkg.sv
verilog/prefix_scan.sv
verilog/attr_table.sv
verilog/attr_arbiter.sv
verilog/attr_loader.sv
verilog/insn_length_calc.sv
verilog/x86_decode_top.sv
verification/x86_decode_tb.sv
